/* logic/uart_pkg.sv */
// ==============================
// Shared definitions for the Apple 1 terminal UART
// Register address codes, character and frame widths,
// status flag position and receiver filter length
// ==============================

`default_nettype none

package uart_pkg;

    // CPU-side register address
    typedef logic [1:0] reg_addr_t;

    // Register map, as seen at 0xD010..0xD012 on the Apple 1
    localparam reg_addr_t addr_rx   = 2'd0;
    localparam reg_addr_t addr_rxcr = 2'd1;
    localparam reg_addr_t addr_tx   = 2'd2;

    // Terminal characters are 7-bit ASCII
    localparam int char_bits = 7;

    // Payload of one 8N1 frame
    localparam int data_bits = 8;

    // Status flag sits in the MSB of every read word
    localparam int flag_bit = 7;

    // Oversample ticks spanned by the receiver majority filter
    localparam int rx_filter_len = 3;

endpackage

`default_nettype wire

/* logic/baud_tick_gen.sv */
// ==============================
// Fractional baud tick generator
// One-cycle tick at an average of rate per second
// ==============================

`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen #(
    parameter int clk_frequency = 25_000_000,
    parameter int rate          = 115_200
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic enable,
    output logic      tick
);

    localparam int acc_w = $clog2(clk_frequency + rate) + 1;

    logic [acc_w-1:0] acc;
    logic [acc_w-1:0] acc_next;

    assign acc_next = acc + acc_w'(rate);

    // Remainder is carried over, so odd ratios average out
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            acc  <= '0;
            tick <= 1'b0;
        end
        else if (!enable)
        begin
            // Held at zero so the first period lines up with enable
            acc  <= '0;
            tick <= 1'b0;
        end
        else if (acc_next >= acc_w'(clk_frequency))
        begin
            acc  <= acc_next - acc_w'(clk_frequency);
            tick <= 1'b1;
        end
        else
        begin
            acc  <= acc_next;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/serial_transmitter.sv */
// ==============================
// 8N1 serial transmitter
// Start strobe, busy level, registered line output
// ==============================

`timescale 1ns/1ps
`default_nettype none

module serial_transmitter #(
    parameter int clk_frequency = 25_000_000,
    parameter int baud          = 115_200
) (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          tx_start,
    input  wire logic [uart_pkg::data_bits-1:0] tx_data,
    output logic                               tx,
    output logic                               tx_busy
);

    localparam int bit_w = $clog2(uart_pkg::data_bits);
    localparam logic [bit_w-1:0] last_bit = bit_w'(uart_pkg::data_bits - 1);

    typedef enum logic [1:0] {
        s_idle,
        s_start,
        s_data,
        s_stop
    } state_t;

    state_t                      state;
    logic [uart_pkg::data_bits-1:0] shift_reg;
    logic [bit_w-1:0]            bit_cnt;
    logic                        baud_tick;

    assign tx_busy = (state != s_idle);

    // Bit clock only runs during a frame
    baud_tick_gen #(
        .clk_frequency (clk_frequency),
        .rate          (baud)
    ) u_baud (
        .clk    (clk),
        .reset  (reset),
        .enable (tx_busy),
        .tick   (baud_tick)
    );

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state   <= s_idle;
            tx      <= 1'b1;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                s_idle:
                begin
                    if (tx_start)
                    begin
                        state <= s_start;
                        tx    <= 1'b0;
                    end
                end
                s_start:
                begin
                    if (baud_tick)
                    begin
                        state   <= s_data;
                        tx      <= shift_reg[0];
                        bit_cnt <= '0;
                    end
                end
                s_data:
                begin
                    if (baud_tick)
                    begin
                        if (bit_cnt == last_bit)
                        begin
                            state <= s_stop;
                            tx    <= 1'b1;
                        end
                        else
                        begin
                            tx      <= shift_reg[1];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default:
                begin
                    // Stop bit, line already at mark
                    if (baud_tick)
                        state <= s_idle;
                end
            endcase
        end
    end

    // Payload shifter, LSB goes out first
    always_ff @(posedge clk)
    begin
        if (state == s_idle && tx_start)
            shift_reg <= tx_data;
        else if (state == s_data && baud_tick)
            shift_reg <= shift_reg >> 1;
    end

    // Register block must respect the busy level it is given
    a_no_start_while_busy: assert property (
        @(posedge clk) disable iff (reset) tx_start |-> !tx_busy
    );

endmodule

`default_nettype wire

/* logic/serial_receiver.sv */
// ==============================
// Oversampling 8N1 serial receiver
// Synchronizer, majority filter, ready pulse
// and line idle detection
// ==============================

`timescale 1ns/1ps
`default_nettype none

module serial_receiver #(
    parameter int clk_frequency = 25_000_000,
    parameter int baud          = 115_200,
    parameter int oversampling  = 8
) (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           rx,
    output logic [uart_pkg::data_bits-1:0]      rx_data,
    output logic                                rx_ready,
    output logic                                rx_idle
);

    localparam int cnt_w = (oversampling > 1) ? $clog2(oversampling) : 1;
    localparam logic [cnt_w-1:0] os_mid  = cnt_w'(oversampling / 2 - 1);
    localparam logic [cnt_w-1:0] os_last = cnt_w'(oversampling - 1);
    localparam int bit_w = $clog2(uart_pkg::data_bits);
    localparam logic [bit_w-1:0] last_bit = bit_w'(uart_pkg::data_bits - 1);

    // One character time of mark, start and stop included
    localparam int gap_limit = (uart_pkg::data_bits + 2) * oversampling;
    localparam int gap_w     = $clog2(gap_limit + 1);

    typedef enum logic [1:0] {
        s_idle,
        s_start,
        s_data,
        s_stop
    } state_t;

    state_t                          state;
    logic [1:0]                      sync;
    logic [uart_pkg::rx_filter_len-1:0] filt_sr;
    logic                            line;
    logic                            os_tick;
    logic [cnt_w-1:0]                os_cnt;
    logic [bit_w-1:0]                bit_cnt;
    logic [uart_pkg::data_bits-1:0]  shift_reg;
    logic [gap_w-1:0]                gap_cnt;

    baud_tick_gen #(
        .clk_frequency (clk_frequency),
        .rate          (baud * oversampling)
    ) u_os_tick (
        .clk    (clk),
        .reset  (reset),
        .enable (1'b1),
        .tick   (os_tick)
    );

    // Two-flop synchronizer, then sample history for the filter
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            sync    <= 2'b11;
            filt_sr <= '1;
        end
        else
        begin
            sync <= {sync[0], rx};
            if (os_tick)
                filt_sr <= {filt_sr[uart_pkg::rx_filter_len-2:0], sync[1]};
        end
    end

    // Majority vote over the recent samples
    always_comb
    begin
        int ones;
        ones = 0;
        for (int i = 0; i < uart_pkg::rx_filter_len; i++)
            ones += int'(filt_sr[i]);
        line = (ones > uart_pkg::rx_filter_len / 2);
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state    <= s_idle;
            os_cnt   <= '0;
            bit_cnt  <= '0;
            rx_ready <= 1'b0;
        end
        else
        begin
            rx_ready <= 1'b0;
            if (os_tick)
            begin
                os_cnt <= os_cnt + 1'b1;
                case (state)
                    s_idle:
                    begin
                        if (!line)
                        begin
                            state  <= s_start;
                            os_cnt <= '0;
                        end
                    end
                    s_start:
                    begin
                        // Recheck at mid start bit, a glitch goes back to idle
                        if (os_cnt == os_mid)
                        begin
                            state   <= line ? s_idle : s_data;
                            os_cnt  <= '0;
                            bit_cnt <= '0;
                        end
                    end
                    s_data:
                    begin
                        if (os_cnt == os_last)
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == last_bit)
                                state <= s_stop;
                        end
                    end
                    default:
                    begin
                        // Bad stop bit drops the byte without a report
                        if (os_cnt == os_last)
                        begin
                            state    <= s_idle;
                            rx_ready <= line;
                        end
                    end
                endcase
            end
        end
    end

    // Data path, LSB arrives first so shift in from the top
    always_ff @(posedge clk)
    begin
        if (os_tick && state == s_data && os_cnt == os_last)
            shift_reg <= {line, shift_reg[uart_pkg::data_bits-1:1]};
        if (os_tick && state == s_stop && os_cnt == os_last)
            rx_data <= shift_reg;
    end

    // Line gap tracking for the idle level
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            gap_cnt <= '0;
            rx_idle <= 1'b1;
        end
        else if (os_tick)
        begin
            if (!line)
                gap_cnt <= '0;
            else if (gap_cnt != gap_w'(gap_limit))
                gap_cnt <= gap_cnt + 1'b1;

            if (state == s_idle && !line)
                rx_idle <= 1'b0;
            else if (state == s_idle && gap_cnt == gap_w'(gap_limit))
                rx_idle <= 1'b1;
        end
    end

    a_ready_single: assert property (
        @(posedge clk) disable iff (reset) rx_ready |=> !rx_ready
    );

endmodule

`default_nettype wire

/* logic/terminal_registers.sv */
// ==============================
// Terminal register block
// Receive holding register and flag, read mux,
// transmit strobe and clear-to-send
// ==============================

`timescale 1ns/1ps
`default_nettype none

module terminal_registers (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           enable,
    input  wire uart_pkg::reg_addr_t            address,
    input  wire logic                           w_en,
    input  wire logic [uart_pkg::data_bits-1:0] din,
    output logic [uart_pkg::data_bits-1:0]      dout,
    output logic                                tx_start,
    output logic [uart_pkg::data_bits-1:0]      tx_data,
    input  wire logic                           tx_busy,
    input  wire logic [uart_pkg::data_bits-1:0] rx_data,
    input  wire logic                           rx_ready,
    input  wire logic                           rx_idle,
    output logic                                cts
);

    localparam int pad_bits = uart_pkg::data_bits - uart_pkg::char_bits;

    logic                           rx_flag;
    logic                           rx_ack;
    logic [uart_pkg::data_bits-1:0] rx_byte;
    logic [uart_pkg::data_bits-1:0] read_word;
    logic                           rd_rx;
    logic                           wr_tx;

    // Hold the byte until the CPU has read it, later arrivals are lost
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            rx_flag <= 1'b0;
        else if (rx_ack)
            rx_flag <= 1'b0;
        else if (rx_ready)
            rx_flag <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rx_ready && !rx_flag)
            rx_byte <= rx_data;
    end

    // Line busy or a character waiting
    assign cts = !rx_idle || rx_flag;

    // Read word for the current address
    always_comb
    begin
        read_word = '0;
        case (address)
            uart_pkg::addr_rx:
            begin
                read_word[uart_pkg::flag_bit]       = rx_flag;
                read_word[uart_pkg::char_bits-1:0]  = rx_byte[uart_pkg::char_bits-1:0];
            end
            uart_pkg::addr_rxcr:
                read_word[uart_pkg::flag_bit] = rx_flag;
            uart_pkg::addr_tx:
                read_word[uart_pkg::flag_bit] = tx_busy;
            default:
                read_word = '0;
        endcase
    end

    // Acknowledge only a held character, once per read
    assign rd_rx = enable && !w_en && address == uart_pkg::addr_rx && rx_flag && !rx_ack;

    // Back-to-back writes must not restart a frame the transmitter
    // has not yet flagged as busy
    assign wr_tx = enable && w_en && address == uart_pkg::addr_tx && !tx_busy && !tx_start;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            dout     <= '0;
            tx_start <= 1'b0;
            rx_ack   <= 1'b0;
        end
        else
        begin
            dout     <= read_word;
            tx_start <= wr_tx;
            rx_ack   <= rd_rx;
        end
    end

    // Terminal only sends 7 bits, top bit forced low
    always_ff @(posedge clk)
    begin
        if (wr_tx)
            tx_data <= {{pad_bits{1'b0}}, din[uart_pkg::char_bits-1:0]};
    end

    // Write gate covers only the strobe cycle before busy rises
    a_busy_after_start: assert property (
        @(posedge clk) disable iff (reset) tx_start |=> tx_busy
    );

endmodule

`default_nettype wire

/* logic/apple1_uart.sv */
// ==============================
// Apple 1 style serial terminal UART
// Register block, transmitter and receiver
// ==============================

`timescale 1ns/1ps
`default_nettype none

module apple1_uart #(
    parameter int clk_frequency = 25_000_000,
    parameter int baud          = 115_200,
    parameter int oversampling  = 8
) (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           enable,
    input  wire uart_pkg::reg_addr_t            address,
    input  wire logic                           w_en,
    input  wire logic [uart_pkg::data_bits-1:0] din,
    output logic [uart_pkg::data_bits-1:0]      dout,
    input  wire logic                           uart_rx,
    output logic                                uart_tx,
    output logic                                uart_cts
);

    logic                           tx_start;
    logic [uart_pkg::data_bits-1:0] tx_data;
    logic                           tx_busy;
    logic [uart_pkg::data_bits-1:0] rx_data;
    logic                           rx_ready;
    logic                           rx_idle;

    terminal_registers u_regs (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .address  (address),
        .w_en     (w_en),
        .din      (din),
        .dout     (dout),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .rx_data  (rx_data),
        .rx_ready (rx_ready),
        .rx_idle  (rx_idle),
        .cts      (uart_cts)
    );

    serial_transmitter #(
        .clk_frequency (clk_frequency),
        .baud          (baud)
    ) u_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx       (uart_tx),
        .tx_busy  (tx_busy)
    );

    serial_receiver #(
        .clk_frequency (clk_frequency),
        .baud          (baud),
        .oversampling  (oversampling)
    ) u_rx (
        .clk      (clk),
        .reset    (reset),
        .rx       (uart_rx),
        .rx_data  (rx_data),
        .rx_ready (rx_ready),
        .rx_idle  (rx_idle)
    );

endmodule

`default_nettype wire

/* verification/apple1_uart_tb.sv */
// ==============================
// Testbench for the terminal UART
// Stimulus table, serial line model,
// compare tasks and polled waits
// ==============================

`timescale 1ns/1ps
`default_nettype none

module apple1_uart_tb;

    localparam int bit_clocks   = 16;
    localparam int frame_limit  = 400;
    localparam int quiet_clocks = 20 * bit_clocks;
    localparam int quiet_limit  = 3000;
    localparam int poll_limit   = 200;
    localparam int cts_limit    = 1000;

    typedef logic [uart_pkg::data_bits-1:0] byte_t;

    typedef enum {
        op_tx_level,
        op_cts_level,
        op_read,
        op_write,
        op_send,
        op_wait_sent,
        op_wait_flag,
        op_frame,
        op_quiet,
        op_wait_cts_low,
        op_delay
    } op_t;

    typedef struct {
        op_t                 op;
        uart_pkg::reg_addr_t addr;
        byte_t               data;
        byte_t               expected;
    } step_t;

    logic                clk;
    logic                reset;
    logic                enable;
    uart_pkg::reg_addr_t address;
    logic                w_en;
    byte_t               din;
    byte_t               dout;
    logic                uart_rx;
    logic                uart_tx;
    logic                uart_cts;

    step_t steps[$];
    byte_t rx_bytes[$];
    byte_t tx_frames[$];
    logic  line_busy;

    apple1_uart #(
        .clk_frequency (1_000_000),
        .baud          (62_500),
        .oversampling  (8)
    ) DUT (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .address  (address),
        .w_en     (w_en),
        .din      (din),
        .dout     (dout),
        .uart_rx  (uart_rx),
        .uart_tx  (uart_tx),
        .uart_cts (uart_cts)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("FAILED at %0t ns: %s", $time, msg));
    endtask

    task automatic check_read(input uart_pkg::reg_addr_t addr, input byte_t got, input byte_t exp);
        if (got !== exp)
            report_mismatch($sformatf("read at address %0d gave %02h, expected %02h",
                                      addr, got, exp));
    endtask

    task automatic check_frame(input byte_t got, input byte_t exp);
        if (got !== exp)
            report_mismatch($sformatf("uart_tx frame %02h, expected %02h", got, exp));
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
    endtask

    // Bus cycles start on a falling edge, one idle cycle after a read
    task automatic bus_read(input uart_pkg::reg_addr_t addr, output byte_t word);
        enable  = 1'b1;
        w_en    = 1'b0;
        address = addr;
        @(negedge clk);
        word   = dout;
        enable = 1'b0;
        @(negedge clk);
    endtask

    task automatic bus_write(input uart_pkg::reg_addr_t addr, input byte_t data);
        enable  = 1'b1;
        w_en    = 1'b1;
        address = addr;
        din     = data;
        @(negedge clk);
        enable = 1'b0;
        w_en   = 1'b0;
    endtask

    // Line driver for uart_rx, start bit, LSB first, one stop bit
    initial
    begin
        logic [9:0] frame;
        uart_rx   = 1'b1;
        line_busy = 1'b0;
        forever
        begin
            @(negedge clk);
            if (rx_bytes.size() != 0)
            begin
                line_busy = 1'b1;
                frame = {1'b1, rx_bytes.pop_front(), 1'b0};
                for (int i = 0; i < 10; i++)
                begin
                    uart_rx = frame[i];
                    repeat (bit_clocks) @(negedge clk);
                end
                line_busy = 1'b0;
            end
        end
    end

    // Frame decoder for uart_tx, samples at bit middles
    initial
    begin
        byte_t data;
        forever
        begin
            @(negedge clk);
            if (!reset && uart_tx === 1'b0)
            begin
                repeat (bit_clocks / 2) @(negedge clk);
                if (uart_tx !== 1'b0)
                    abort_run("Start bit on uart_tx did not last to its middle");
                for (int i = 0; i < uart_pkg::data_bits; i++)
                begin
                    repeat (bit_clocks) @(negedge clk);
                    data[i] = uart_tx;
                end
                repeat (bit_clocks) @(negedge clk);
                if (uart_tx !== 1'b1)
                    abort_run("Stop bit on uart_tx was missing");
                tx_frames.push_back(data);
            end
        end
    end

    task automatic wait_tx_frame(output byte_t data);
        int cycles;
        cycles = 0;
        while (tx_frames.size() == 0)
        begin
            if (cycles == frame_limit)
                abort_run("Timed out waiting for a frame on uart_tx");
            @(negedge clk);
            cycles++;
        end
        data = tx_frames.pop_front();
    endtask

    // Line must stay at mark for two character times with nothing decoded
    task automatic wait_tx_quiet();
        int cycles;
        int high_run;
        cycles   = 0;
        high_run = 0;
        while (high_run < quiet_clocks)
        begin
            if (cycles == quiet_limit)
                abort_run("Timed out waiting for uart_tx to stay idle");
            @(negedge clk);
            high_run = (uart_tx === 1'b1) ? high_run + 1 : 0;
            cycles++;
        end
        if (tx_frames.size() != 0)
            abort_run("An extra frame was sent after a write while the transmitter was busy");
    endtask

    task automatic wait_line_sent();
        int cycles;
        cycles = 0;
        while (rx_bytes.size() != 0 || line_busy)
        begin
            if (cycles == frame_limit)
                abort_run("Timed out waiting for the uart_rx line model to finish a byte");
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_ready_flag();
        byte_t word;
        int    polls;
        word  = '0;
        polls = 0;
        while (!word[uart_pkg::flag_bit])
        begin
            if (polls == poll_limit)
                abort_run("Timed out waiting for the receive ready flag");
            bus_read(uart_pkg::addr_rxcr, word);
            polls++;
        end
    endtask

    task automatic wait_cts_low();
        int cycles;
        cycles = 0;
        while (uart_cts !== 1'b0)
        begin
            if (cycles == cts_limit)
                abort_run("Timed out waiting for uart_cts to fall");
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic run_step(input step_t s);
        byte_t word;
        case (s.op)
            op_tx_level:     check_level("uart_tx", uart_tx, s.expected[0]);
            op_cts_level:    check_level("uart_cts", uart_cts, s.expected[0]);
            op_write:        bus_write(s.addr, s.data);
            op_send:         rx_bytes.push_back(s.data);
            op_wait_sent:    wait_line_sent();
            op_wait_flag:    wait_ready_flag();
            op_quiet:        wait_tx_quiet();
            op_wait_cts_low: wait_cts_low();
            op_read:
            begin
                bus_read(s.addr, word);
                check_read(s.addr, word, s.expected);
            end
            op_frame:
            begin
                wait_tx_frame(word);
                check_frame(word, s.expected);
            end
            default:         repeat (s.data) @(negedge clk);
        endcase
    endtask

    function automatic void add_step(input op_t op, input uart_pkg::reg_addr_t addr,
                                     input byte_t data, input byte_t expected);
        step_t s;
        s.op       = op;
        s.addr     = addr;
        s.data     = data;
        s.expected = expected;
        steps.push_back(s);
    endfunction

    // Terminal sends only the low character bits, bit 7 cleared
    function automatic byte_t sent_char(input byte_t b);
        return {1'b0, b[uart_pkg::char_bits-1:0]};
    endfunction

    // Receive register shows the flag over the character
    function automatic byte_t held_char(input byte_t b);
        return {1'b1, b[uart_pkg::char_bits-1:0]};
    endfunction

    initial
    begin
        byte_t rnd[6];
        void'($urandom(32'h7c41_f36e));
        reset   = 1'b1;
        enable  = 1'b0;
        w_en    = 1'b0;
        address = uart_pkg::addr_rx;
        din     = '0;
        for (int i = 0; i < 6; i++)
            rnd[i] = byte_t'($urandom());
        rnd[0][7] = 1'b1;
        rnd[5]    = rnd[4] ^ 8'h55;

        // Reset levels
        add_step(op_tx_level, uart_pkg::addr_rx, 8'h00, 8'h01);
        add_step(op_cts_level, uart_pkg::addr_rx, 8'h00, 8'h00);
        add_step(op_read, uart_pkg::addr_rxcr, 8'h00, 8'h00);
        add_step(op_read, uart_pkg::addr_tx, 8'h00, 8'h00);
        // Transmit, with a second write while busy
        add_step(op_write, uart_pkg::addr_tx, rnd[0], 8'h00);
        add_step(op_write, uart_pkg::addr_tx, rnd[1], 8'h00);
        add_step(op_read, uart_pkg::addr_tx, 8'h00, 8'h80);
        add_step(op_write, uart_pkg::addr_tx, rnd[1], 8'h00);
        add_step(op_frame, uart_pkg::addr_rx, 8'h00, sent_char(rnd[0]));
        add_step(op_quiet, uart_pkg::addr_rx, 8'h00, 8'h00);
        add_step(op_read, uart_pkg::addr_tx, 8'h00, 8'h00);
        add_step(op_write, uart_pkg::addr_tx, rnd[2], 8'h00);
        add_step(op_frame, uart_pkg::addr_rx, 8'h00, sent_char(rnd[2]));
        add_step(op_quiet, uart_pkg::addr_rx, 8'h00, 8'h00);
        // Receive, cts during the frame and while unread
        add_step(op_send, uart_pkg::addr_rx, rnd[3], 8'h00);
        add_step(op_delay, uart_pkg::addr_rx, 8'd40, 8'h00);
        add_step(op_cts_level, uart_pkg::addr_rx, 8'h00, 8'h01);
        add_step(op_wait_flag, uart_pkg::addr_rx, 8'h00, 8'h00);
        // Line has gone idle by now, only the held character keeps cts up
        add_step(op_delay, uart_pkg::addr_rx, 8'd240, 8'h00);
        add_step(op_cts_level, uart_pkg::addr_rx, 8'h00, 8'h01);
        add_step(op_read, uart_pkg::addr_rxcr, 8'h00, 8'h80);
        add_step(op_read, uart_pkg::addr_rx, 8'h00, held_char(rnd[3]));
        add_step(op_read, uart_pkg::addr_rxcr, 8'h00, 8'h00);
        add_step(op_wait_cts_low, uart_pkg::addr_rx, 8'h00, 8'h00);
        // Second byte arrives before the first is read
        add_step(op_send, uart_pkg::addr_rx, rnd[4], 8'h00);
        add_step(op_wait_flag, uart_pkg::addr_rx, 8'h00, 8'h00);
        add_step(op_send, uart_pkg::addr_rx, rnd[5], 8'h00);
        add_step(op_wait_sent, uart_pkg::addr_rx, 8'h00, 8'h00);
        add_step(op_delay, uart_pkg::addr_rx, 8'd16, 8'h00);
        add_step(op_read, uart_pkg::addr_rx, 8'h00, held_char(rnd[4]));
        add_step(op_read, uart_pkg::addr_rxcr, 8'h00, 8'h00);
        add_step(op_wait_cts_low, uart_pkg::addr_rx, 8'h00, 8'h00);

        repeat (4) @(negedge clk);
        reset = 1'b0;
        foreach (steps[i])
            run_step(steps[i]);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* apple1_uart.f */
logic/uart_pkg.sv
logic/baud_tick_gen.sv
logic/serial_transmitter.sv
logic/serial_receiver.sv
logic/terminal_registers.sv
logic/apple1_uart.sv
verification/apple1_uart_tb.sv

/* Makefile */
# Verilator build and run of the Apple 1 terminal UART testbench

TOP = apple1_uart_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check its log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f apple1_uart.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
